//--- design/elinkPkg.sv
// Shared types and 8b10b special codes for the E-link loopback
// Symbols are written abcdei_fghj with bit a in bit 9
// Only K28.1, K28.5 and K28.6 are known to the link
package elinkPkg;

  localparam int SymW = 10;  // One 8b10b symbol

  // Delimiter carried with every byte
  typedef enum logic [1:0] {
    delimData = 2'd0,  // Plain D.x.y byte
    delimSop  = 2'd1,  // K28.1
    delimEop  = 2'd2,  // K28.6
    delimIdle = 2'd3   // K28.5, also the comma
  } delimT;

  // Register map of the config block
  typedef enum logic [1:0] {
    addrCtrl     = 2'd0,
    addrStatus   = 2'd1,
    addrErrCount = 2'd2
  } CfgAddrT;

  // Neg form is sent at negative running disparity
  localparam logic [SymW-1:0] K285Neg = 10'b001111_1010;
  localparam logic [SymW-1:0] K285Pos = 10'b110000_0101;
  localparam logic [SymW-1:0] K281Neg = 10'b001111_1001;
  localparam logic [SymW-1:0] K281Pos = 10'b110000_0110;
  localparam logic [SymW-1:0] K286Neg = 10'b001111_0110;
  localparam logic [SymW-1:0] K286Pos = 10'b110000_1001;

endpackage

//--- design/elinkCfg.sv
// Control and status registers of the E-link loopback
// ctrl bits: 0 txEnable, 1 swapOut, 2 swapIn, 3 reverse10b
// status bits: 0 aligned (live), 1 overflow (sticky, write 1 to clear)
// Any write to errCount clears it; the counter saturates at 255
module elinkCfg
(
  input  logic              getDataTrig,
  input  logic              rstN,
  input  logic              cfgWr,
  input  elinkPkg::CfgAddrT cfgAddr,
  input  logic [7:0]        cfgWdata,
  input  logic              codeErr,
  input  logic              aligned,
  input  logic              overflowSet,
  output logic [7:0]        cfgRdata,
  output logic              txEnable,
  output logic              swapOut,
  output logic              swapIn,
  output logic              reverse10b
);
  import elinkPkg::*;

  logic       overflow;  // Sticky FIFO overflow
  logic [7:0] errCount;  // Code error count

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      {reverse10b, swapIn, swapOut, txEnable} <= 4'b0000;
      overflow <= 1'b0;
      errCount <= 8'd0;
    end
    else
    begin
      if (cfgWr && cfgAddr == addrCtrl)
        {reverse10b, swapIn, swapOut, txEnable} <= cfgWdata[3:0];
      // New overflow wins over clear
      if (overflowSet)
        overflow <= 1'b1;
      else if (cfgWr && cfgAddr == addrStatus && cfgWdata[1])
        overflow <= 1'b0;
      if (cfgWr && cfgAddr == addrErrCount)
        errCount <= 8'd0;
      else if (codeErr && errCount != 8'hFF)
        errCount <= errCount + 8'd1;  // Saturating
    end
  end

  // Readback, no side effects
  always_comb
  begin
    case (cfgAddr)
      addrCtrl:     cfgRdata = {4'b0000, reverse10b, swapIn, swapOut, txEnable};
      addrStatus:   cfgRdata = {6'b000000, overflow, aligned};
      addrErrCount: cfgRdata = errCount;
      default:      cfgRdata = 8'd0;
    endcase
  end

endmodule

//--- design/enc8b10b.sv
// 8b10b encoder, one symbol slot every 5 clocks
// wordReq pulses once per slot; the word is sampled on the clock after it
// A slot without wordValid, or with txEnable low, sends a K28.5 comma
// Running disparity starts negative after reset
module enc8b10b
(
  input  logic                      getDataTrig,
  input  logic                      rstN,
  input  logic                      txEnable,
  input  logic                      wordValid,
  input  elinkPkg::delimT           txDelim,
  input  logic [7:0]                txByte,
  output logic                      wordReq,
  output logic [elinkPkg::SymW-1:0] txSym,
  output logic                      symStb
);
  import elinkPkg::*;

  logic [2:0]      slot;       // Slot phase 0..4
  logic            reqD;       // Sample now
  logic            encNow;     // Encode now
  logic            rdPos;      // Running disparity, 1 is positive
  delimT           holdDelim;  // Sampled word
  logic [7:0]      holdByte;
  logic [SymW-1:0] symNext;
  logic            rdNext;

  // 5b/6b table, RD- column
  function automatic logic [5:0] enc6(input logic [4:0] x);
    case (x)
      5'd0:    return 6'b100111;
      5'd1:    return 6'b011101;
      5'd2:    return 6'b101101;
      5'd3:    return 6'b110001;
      5'd4:    return 6'b110101;
      5'd5:    return 6'b101001;
      5'd6:    return 6'b011001;
      5'd7:    return 6'b111000;
      5'd8:    return 6'b111001;
      5'd9:    return 6'b100101;
      5'd10:   return 6'b010101;
      5'd11:   return 6'b110100;
      5'd12:   return 6'b001101;
      5'd13:   return 6'b101100;
      5'd14:   return 6'b011100;
      5'd15:   return 6'b010111;
      5'd16:   return 6'b011011;
      5'd17:   return 6'b100011;
      5'd18:   return 6'b010011;
      5'd19:   return 6'b110010;
      5'd20:   return 6'b001011;
      5'd21:   return 6'b101010;
      5'd22:   return 6'b011010;
      5'd23:   return 6'b111010;
      5'd24:   return 6'b110011;
      5'd25:   return 6'b100110;
      5'd26:   return 6'b010110;
      5'd27:   return 6'b110110;
      5'd28:   return 6'b001110;
      5'd29:   return 6'b101110;
      5'd30:   return 6'b011110;
      default: return 6'b101011;  // D.31
    endcase
  endfunction

  // 3b/4b table, RD- column, primary D.x.7
  function automatic logic [3:0] enc4(input logic [2:0] y);
    case (y)
      3'd0:    return 4'b1011;
      3'd1:    return 4'b1001;
      3'd2:    return 4'b0101;
      3'd3:    return 4'b1100;
      3'd4:    return 4'b1101;
      3'd5:    return 4'b1010;
      3'd6:    return 4'b0110;
      default: return 4'b1110;
    endcase
  endfunction

  always_comb
  begin
    logic [5:0] c6;
    logic [3:0] c4;
    logic       rd6;
    logic       alt7;
    logic [4:0] x;
    x  = holdByte[4:0];
    c6 = enc6(x);
    if (rdPos && ($countones(c6) != 3 || c6 == 6'b111000))
      c6 = ~c6;  // RD+ form, D.7 included
    rd6 = ($countones(c6) != 3) ? ~rdPos : rdPos;
    // A7 avoids a run of five equal bits
    alt7 = (holdByte[7:5] == 3'd7) &&
           ((!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
            (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
    c4 = alt7 ? 4'b0111 : enc4(holdByte[7:5]);
    if (rd6 && ($countones(c4) != 2 || c4 == 4'b1100))
      c4 = ~c4;
    case (holdDelim)
      delimSop:  symNext = rdPos ? K281Pos : K281Neg;
      delimEop:  symNext = rdPos ? K286Pos : K286Neg;
      delimIdle: symNext = rdPos ? K285Pos : K285Neg;
      default:   symNext = {c6, c4};
    endcase
    // K28.x codes always flip disparity
    if (holdDelim == delimData)
      rdNext = ($countones(c4) != 2) ? ~rd6 : rd6;
    else
      rdNext = ~rdPos;
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      slot    <= 3'd0;
      wordReq <= 1'b0;
      reqD    <= 1'b0;
      encNow  <= 1'b0;
      symStb  <= 1'b0;
      rdPos   <= 1'b0;
    end
    else
    begin
      slot    <= (slot == 3'd4) ? 3'd0 : slot + 3'd1;
      wordReq <= (slot == 3'd4);  // One pulse per slot
      reqD    <= wordReq;
      encNow  <= reqD;
      symStb  <= encNow;          // With txSym
      if (encNow)
        rdPos <= rdNext;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (reqD)
    begin
      holdDelim <= (wordValid && txEnable) ? txDelim : delimIdle;
      holdByte  <= txByte;
    end
    if (encNow)
      txSym <= symNext;
  end

endmodule

//--- design/elinkSer.sv
// 10-to-2 serializer, bit pair txSym[1:0] leaves first
// reverse10b flips the symbol bit order; swapOut swaps bits within a pair
// Expects a symStb every 5 clocks, otherwise zeros are shifted out
module elinkSer
(
  input  logic                      getDataTrig,
  input  logic                      rstN,
  input  logic [elinkPkg::SymW-1:0] txSym,
  input  logic                      symStb,
  input  logic                      reverse10b,
  input  logic                      swapOut,
  output logic [1:0]                edataOut
);
  import elinkPkg::*;

  logic [SymW-1:0] loadSym;  // Symbol in send order
  logic [SymW-1:0] shReg;    // Pairs still to send

  always_comb
  begin
    if (reverse10b)
      loadSym = {<<{txSym}};
    else
      loadSym = txSym;
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
      shReg <= '0;
    else if (symStb)
      shReg <= loadSym;
    else
      shReg <= {2'b00, shReg[SymW-1:2]};  // Next pair
  end

  assign edataOut = swapOut ? {shReg[0], shReg[1]} : shReg[1:0];

endmodule

//--- design/elinkDes.sv
// 2-to-10 deserializer with comma alignment
// Locks after LockCount K28.5 commas in a row at one pair phase
// Unlocks after LockCount non-comma symbols at the locked phase once a
// comma has shown up at another phase
module elinkDes
#(
  parameter int LockCount = 3
)
(
  input  logic                      getDataTrig,
  input  logic                      rstN,
  input  logic [1:0]                edataIn,
  input  logic                      swapIn,
  input  logic                      reverse10b,
  output logic [elinkPkg::SymW-1:0] rxSym,
  output logic                      rxStb,
  output logic                      aligned
);
  import elinkPkg::*;

  localparam int CntW = $clog2(LockCount + 1);

  logic [1:0]      pairIn;
  logic [SymW-1:0] win;         // Last five pairs
  logic [SymW-1:0] cand;        // Window in symbol order
  logic [2:0]      phase;       // Pair position mod 5
  logic [2:0]      lockPhase;   // Candidate or locked phase
  logic [CntW-1:0] cnt;         // Comma run or miss run
  logic            otherComma;  // Comma seen off the locked phase
  logic            isComma;

  assign pairIn = swapIn ? {edataIn[0], edataIn[1]} : edataIn;

  always_comb
  begin
    if (reverse10b)
      cand = {<<{win}};
    else
      cand = win;
  end

  assign isComma = (cand == K285Neg) || (cand == K285Pos);

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      win        <= '0;
      phase      <= 3'd0;
      lockPhase  <= 3'd0;
      cnt        <= '0;
      otherComma <= 1'b0;
      aligned    <= 1'b0;
      rxStb      <= 1'b0;
    end
    else
    begin
      win   <= {pairIn, win[SymW-1:2]};  // Newest pair on top
      phase <= (phase == 3'd4) ? 3'd0 : phase + 3'd1;
      rxStb <= aligned && (phase == lockPhase);
      if (!aligned)
      begin
        if (isComma && phase == lockPhase)
        begin
          if (cnt == CntW'(LockCount - 1))
          begin
            aligned    <= 1'b1;  // Locked here
            cnt        <= '0;
            otherComma <= 1'b0;
          end
          else
            cnt <= cnt + 1'b1;
        end
        else if (isComma)
        begin
          lockPhase <= phase;  // New candidate phase
          cnt       <= CntW'(1);
        end
        else if (phase == lockPhase)
          cnt <= '0;  // Run broken
      end
      else if (isComma && phase != lockPhase)
        otherComma <= 1'b1;
      else if (phase == lockPhase)
      begin
        if (isComma)
        begin
          cnt        <= '0;  // Lock confirmed
          otherComma <= 1'b0;
        end
        else if (otherComma)
        begin
          if (cnt == CntW'(LockCount - 1))
          begin
            aligned    <= 1'b0;  // Lost, search again
            cnt        <= '0;
            otherComma <= 1'b0;
          end
          else
            cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (phase == lockPhase)
      rxSym <= cand;
  end

endmodule

//--- design/dec8b10b.sv
// 8b10b decoder, one symbol per rxStb
// codeErr pulses with decStb on an unknown sub-block or a disparity error
// A K28.5 comma of either form resets the running disparity, so lock
// after a link gap does not leave a false disparity error
module dec8b10b
(
  input  logic                      getDataTrig,
  input  logic                      rstN,
  input  logic [elinkPkg::SymW-1:0] rxSym,
  input  logic                      rxStb,
  output elinkPkg::delimT           rxDelim,
  output logic [7:0]                rxByte,
  output logic                      decStb,
  output logic                      codeErr
);
  import elinkPkg::*;

  logic  rdPos;  // Running disparity, 1 is positive
  logic  rdNext;
  logic  errNext;
  delimT delimNext;
  logic  [7:0] byteNext;

  // 6b to 5b, MSB is the valid flag
  function automatic logic [5:0] dec6(input logic [5:0] c);
    case (c)
      6'b100111, 6'b011000: return {1'b1, 5'd0};
      6'b011101, 6'b100010: return {1'b1, 5'd1};
      6'b101101, 6'b010010: return {1'b1, 5'd2};
      6'b110001:            return {1'b1, 5'd3};
      6'b110101, 6'b001010: return {1'b1, 5'd4};
      6'b101001:            return {1'b1, 5'd5};
      6'b011001:            return {1'b1, 5'd6};
      6'b111000, 6'b000111: return {1'b1, 5'd7};
      6'b111001, 6'b000110: return {1'b1, 5'd8};
      6'b100101:            return {1'b1, 5'd9};
      6'b010101:            return {1'b1, 5'd10};
      6'b110100:            return {1'b1, 5'd11};
      6'b001101:            return {1'b1, 5'd12};
      6'b101100:            return {1'b1, 5'd13};
      6'b011100:            return {1'b1, 5'd14};
      6'b010111, 6'b101000: return {1'b1, 5'd15};
      6'b011011, 6'b100100: return {1'b1, 5'd16};
      6'b100011:            return {1'b1, 5'd17};
      6'b010011:            return {1'b1, 5'd18};
      6'b110010:            return {1'b1, 5'd19};
      6'b001011:            return {1'b1, 5'd20};
      6'b101010:            return {1'b1, 5'd21};
      6'b011010:            return {1'b1, 5'd22};
      6'b111010, 6'b000101: return {1'b1, 5'd23};
      6'b110011, 6'b001100: return {1'b1, 5'd24};
      6'b100110:            return {1'b1, 5'd25};
      6'b010110:            return {1'b1, 5'd26};
      6'b110110, 6'b001001: return {1'b1, 5'd27};
      6'b001110:            return {1'b1, 5'd28};
      6'b101110, 6'b010001: return {1'b1, 5'd29};
      6'b011110, 6'b100001: return {1'b1, 5'd30};
      6'b101011, 6'b010100: return {1'b1, 5'd31};
      default:              return 6'd0;
    endcase
  endfunction

  // 4b to 3b, both D.x.7 forms
  function automatic logic [3:0] dec4(input logic [3:0] c);
    case (c)
      4'b1011, 4'b0100:                   return {1'b1, 3'd0};
      4'b1001:                            return {1'b1, 3'd1};
      4'b0101:                            return {1'b1, 3'd2};
      4'b1100, 4'b0011:                   return {1'b1, 3'd3};
      4'b1101, 4'b0010:                   return {1'b1, 3'd4};
      4'b1010:                            return {1'b1, 3'd5};
      4'b0110:                            return {1'b1, 3'd6};
      4'b1110, 4'b0001, 4'b0111, 4'b1000: return {1'b1, 3'd7};
      default:                            return 4'd0;
    endcase
  endfunction

  always_comb
  begin
    logic [5:0] r6;
    logic [3:0] r4;
    int         n6;
    int         n4;
    logic       rd6;
    logic       bad;
    r6  = dec6(rxSym[9:4]);
    r4  = dec4(rxSym[3:0]);
    n6  = $countones(rxSym[9:4]);
    n4  = $countones(rxSym[3:0]);
    bad = (n6 > 3 && rdPos) || (n6 < 3 && !rdPos);  // Sign must oppose RD
    rd6 = (n6 != 3) ? ~rdPos : rdPos;
    bad = bad || (n4 > 2 && rd6) || (n4 < 2 && !rd6);
    rdNext    = (n4 != 2) ? ~rd6 : rd6;
    errNext   = !r6[5] || !r4[3] || bad;
    delimNext = delimData;
    byteNext  = {r4[2:0], r6[4:0]};
    if (rxSym == K285Neg || rxSym == K285Pos)
    begin
      delimNext = delimIdle;
      errNext   = 1'b0;
      rdNext    = (rxSym == K285Neg);  // Resync
    end
    else if (rxSym == K281Neg || rxSym == K281Pos)
    begin
      delimNext = delimSop;
      errNext   = (rxSym == K281Neg) == rdPos;
      rdNext    = (rxSym == K281Neg);
    end
    else if (rxSym == K286Neg || rxSym == K286Pos)
    begin
      delimNext = delimEop;
      errNext   = (rxSym == K286Neg) == rdPos;
      rdNext    = (rxSym == K286Neg);
    end
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      rdPos   <= 1'b0;
      decStb  <= 1'b0;
      codeErr <= 1'b0;
    end
    else
    begin
      decStb  <= rxStb;
      codeErr <= rxStb && errNext;  // One pulse per bad symbol
      if (rxStb)
        rdPos <= rdNext;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (rxStb)
    begin
      rxDelim <= delimNext;
      rxByte  <= byteNext;
    end
  end

endmodule

//--- design/elinkRxFifo.sv
// Receive FIFO of delimiter and byte pairs, first-word-fall-through
// FifoDepth must be a power of two
// A write into a full FIFO is dropped and pulses overflowSet
module elinkRxFifo
#(
  parameter int FifoDepth = 16
)
(
  input  logic            getDataTrig,
  input  logic            rstN,
  input  logic            wrEn,
  input  elinkPkg::delimT wrDelim,
  input  logic [7:0]      wrByte,
  input  logic            fifoRd,
  output elinkPkg::delimT fifoDelim,
  output logic [7:0]      fifoByte,
  output logic            fifoEmpty,
  output logic            fifoFull,
  output logic            overflowSet
);
  import elinkPkg::*;

  localparam int AddrW = $clog2(FifoDepth);

  delimT            memDelim [FifoDepth];
  logic [7:0]       memByte  [FifoDepth];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [AddrW:0]   count;  // Entries held
  logic             doWr;
  logic             doRd;

  assign fifoEmpty   = (count == '0);
  assign fifoFull    = (count == (AddrW + 1)'(FifoDepth));
  assign doWr        = wrEn && !fifoFull;
  assign doRd        = fifoRd && !fifoEmpty;  // Read of empty ignored
  assign overflowSet = wrEn && fifoFull;
  assign fifoDelim   = memDelim[rdPtr];       // Head word
  assign fifoByte    = memByte[rdPtr];

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWr)
        wrPtr <= wrPtr + 1'b1;  // Wraps at FifoDepth
      if (doRd)
        rdPtr <= rdPtr + 1'b1;
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (doWr)
    begin
      memDelim[wrPtr] <= wrDelim;
      memByte[wrPtr]  <= wrByte;
    end
  end

endmodule

//--- design/elinkLoop.sv
// E-link loopback top: 8b10b transmit chain, receive chain, registers
// edataOut and edataIn are looped outside, any skew in whole bit pairs
// Idle and errored symbols never reach the FIFO
module elinkLoop
#(
  parameter int FifoDepth = 16,
  parameter int LockCount = 3
)
(
  input  logic              getDataTrig,
  input  logic              rstN,
  input  logic              cfgWr,
  input  elinkPkg::CfgAddrT cfgAddr,
  input  logic [7:0]        cfgWdata,
  input  logic              wordValid,
  input  elinkPkg::delimT   txDelim,
  input  logic [7:0]        txByte,
  input  logic [1:0]        edataIn,
  input  logic              fifoRd,
  output logic [7:0]        cfgRdata,
  output logic              wordReq,
  output logic [1:0]        edataOut,
  output elinkPkg::delimT   fifoDelim,
  output logic [7:0]        fifoByte,
  output logic              fifoEmpty,
  output logic              fifoFull
);
  import elinkPkg::*;

  logic            txEnable;
  logic            swapOut;
  logic            swapIn;
  logic            reverse10b;
  logic [SymW-1:0] txSym;
  logic            symStb;
  logic [SymW-1:0] rxSym;
  logic            rxStb;
  logic            aligned;
  delimT           rxDelim;
  logic [7:0]      rxByte;
  logic            decStb;
  logic            codeErr;
  logic            fifoWr;
  logic            overflowSet;

  // Keep only good data and packet markers
  assign fifoWr = decStb && !codeErr && (rxDelim != delimIdle);

  elinkCfg uCfg
  (
    .getDataTrig,
    .rstN,
    .cfgWr,
    .cfgAddr,
    .cfgWdata,
    .codeErr,
    .aligned,
    .overflowSet,
    .cfgRdata,
    .txEnable,
    .swapOut,
    .swapIn,
    .reverse10b
  );

  enc8b10b uEnc
  (
    .getDataTrig,
    .rstN,
    .txEnable,
    .wordValid,
    .txDelim,
    .txByte,
    .wordReq,
    .txSym,
    .symStb
  );

  elinkSer uSer
  (
    .getDataTrig,
    .rstN,
    .txSym,
    .symStb,
    .reverse10b,
    .swapOut,
    .edataOut
  );

  elinkDes #(.LockCount(LockCount)) uDes
  (
    .getDataTrig,
    .rstN,
    .edataIn,
    .swapIn,
    .reverse10b,
    .rxSym,
    .rxStb,
    .aligned
  );

  dec8b10b uDec
  (
    .getDataTrig,
    .rstN,
    .rxSym,
    .rxStb,
    .rxDelim,
    .rxByte,
    .decStb,
    .codeErr
  );

  elinkRxFifo #(.FifoDepth(FifoDepth)) uFifo
  (
    .getDataTrig,
    .rstN,
    .wrEn    (fifoWr),
    .wrDelim (rxDelim),
    .wrByte  (rxByte),
    .fifoRd,
    .fifoDelim,
    .fifoByte,
    .fifoEmpty,
    .fifoFull,
    .overflowSet
  );

endmodule

//--- test/elinkLoop_chk.sv
// Strobe and FIFO rules, bound into every elinkLoop instance
// Checks are idle while rstN is low
// assertFails counts failures so the testbench can end the run
module elinkLoopChk
(
  input logic getDataTrig,
  input logic rstN,
  input logic wordReq,
  input logic fifoEmpty,
  input logic fifoFull,
  input logic fifoWr,
  input logic overflowSet
);
  timeunit 1ns;
  timeprecision 100ps;

  int assertFails = 0;  // Failure count

  // One request per symbol slot
  wordReqSingle: assert property (@(posedge getDataTrig) disable iff (!rstN)
    wordReq |=> !wordReq)
  else
  begin
    $error("wordReq high on two clocks in a row");
    assertFails++;
  end

  fifoFlagsExclusive: assert property (@(posedge getDataTrig) disable iff (!rstN)
    !(fifoEmpty && fifoFull))
  else
  begin
    $error("fifoEmpty and fifoFull high together");
    assertFails++;
  end

  // Dropped write must be flagged
  fullWriteFlagged: assert property (@(posedge getDataTrig) disable iff (!rstN)
    (fifoWr && fifoFull) |-> overflowSet)
  else
  begin
    $error("Write into full FIFO without overflowSet");
    assertFails++;
  end

endmodule

bind elinkLoop elinkLoopChk uChk
(
  .getDataTrig,
  .rstN,
  .wordReq,
  .fifoEmpty,
  .fifoFull,
  .fifoWr,
  .overflowSet
);

//--- test/tbElinkLoop.sv
// Loopback testbench where edataOut returns to edataIn through 0 to 4 pair delays
// A word is presented on each wordReq
// Bytes of packet markers are not compared
// Single-bit flip hits bit b of a D.0.0 symbol and always gives an invalid 6b block
module tbElinkLoop;
  timeunit 1ns;
  timeprecision 100ps;

  import elinkPkg::*;

  localparam int FifoDepth = 16;
  localparam int LockCount = 3;

  logic       getDataTrig = 1'b0;
  logic       rstN;
  logic       cfgWr;
  CfgAddrT    cfgAddr;
  logic [7:0] cfgWdata;
  logic       wordValid = 1'b0;
  delimT      txDelim = delimIdle;
  logic [7:0] txByte = 8'h00;
  logic [1:0] edataIn;
  logic       fifoRd = 1'b0;
  logic [7:0] cfgRdata;
  logic       wordReq;
  logic [1:0] edataOut;
  delimT      fifoDelim;
  logic [7:0] fifoByte;
  logic       fifoEmpty;
  logic       fifoFull;

  logic [11:0] sendQ[$];  // {corrupt, valid, delim, byte}
  logic [9:0]  expQ[$];   // {delim, byte} still due from the FIFO
  logic [11:0] nextWord;
  logic [10:0] refWord;
  logic [9:0]  headWord;
  logic [7:0]  gotByte;
  logic [1:0]  pairDly [4] = '{default: 2'b00};
  logic [1:0]  tap;
  logic [1:0]  flipMask = 2'b00;
  int          flipCnt = 0;
  int          delayPairs;
  logic        readEn;    // Compare process may pop
  logic        expectOn;  // Sent words are due in the FIFO
  integer      seed = 32'h7ec6_0700;

  always #5 getDataTrig = ~getDataTrig;

  elinkLoop #(.FifoDepth(FifoDepth), .LockCount(LockCount)) UUT
  (
    .getDataTrig,
    .rstN,
    .cfgWr,
    .cfgAddr,
    .cfgWdata,
    .wordValid,
    .txDelim,
    .txByte,
    .edataIn,
    .fifoRd,
    .cfgRdata,
    .wordReq,
    .edataOut,
    .fifoDelim,
    .fifoByte,
    .fifoEmpty,
    .fifoFull
  );

  // Link skew in whole pairs
  always @(posedge getDataTrig)
  begin
    pairDly[0] <= edataOut;
    for (int k = 1; k < 4; k++)
      pairDly[k] <= pairDly[k-1];
  end

  always_comb
  begin
    if (delayPairs == 0)
      tap = edataOut;
    else
      tap = pairDly[delayPairs-1];
  end

  assign edataIn = tap ^ flipMask;  // Flip only for one pair

  // Expected FIFO word for one sent word with bit 10 set when kept
  function automatic logic [10:0] expectWord(input logic valid, input delimT delim,
                                             input logic [7:0] data);
    if (!valid || delim == delimIdle)
      return 11'd0;                   // Idle never reaches the FIFO
    if (delim == delimData)
      return {1'b1, delim, data};
    return {1'b1, delim, 8'h00};      // Marker byte means nothing
  endfunction

  task automatic failNow(input string why);
    $display("%s at %0t ns", why, $time);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkEqual(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped");
    end
  endtask

  // Source presents one word per wordReq
  always @(posedge getDataTrig)
  begin
    if (flipCnt != 0)
      flipCnt <= flipCnt - 1;
    flipMask <= (flipCnt == 1) ? 2'b01 : 2'b00;
    if (wordReq)
    begin
      if (sendQ.size() != 0)
      begin
        nextWord = sendQ.pop_front();
        wordValid <= nextWord[10];
        txDelim   <= delimT'(nextWord[9:8]);
        txByte    <= nextWord[7:0];
        refWord   = expectWord(nextWord[10], delimT'(nextWord[9:8]), nextWord[7:0]);
        // Flip lands on pair 4 after sample, encode and load
        if (nextWord[11])
          flipCnt <= 7 + delayPairs;
        else if (expectOn && refWord[10])
          expQ.push_back(refWord[9:0]);
      end
      else
        wordValid <= 1'b0;  // Encoder sends a comma
    end
  end

  // Compare the FIFO head then pop it
  always @(posedge getDataTrig)
  begin
    if (fifoRd)
      fifoRd <= 1'b0;  // Pop happens on this edge
    else if (rstN && readEn && !fifoEmpty)
    begin
      if (expQ.size() == 0)
        failNow("FIFO holds a word that was never expected");
      else
      begin
        headWord = expQ.pop_front();
        gotByte  = (fifoDelim == delimData) ? fifoByte : 8'h00;
        checkEqual({fifoDelim, gotByte}, headWord, "FIFO delimiter and byte");
        fifoRd <= 1'b1;
      end
    end
  end

  always @(posedge getDataTrig)
  begin
    if (UUT.uChk.assertFails != 0)
      failNow("A bound assertion failed");
  end

  task automatic resetDut();
    @(posedge getDataTrig);
    rstN <= 1'b0;
    repeat (5) @(posedge getDataTrig);
    rstN <= 1'b1;
  endtask

  task automatic writeReg(input CfgAddrT addr, input logic [7:0] data);
    @(posedge getDataTrig);
    cfgWr    <= 1'b1;
    cfgAddr  <= addr;
    cfgWdata <= data;
    @(posedge getDataTrig);
    cfgWr <= 1'b0;
  endtask

  // Combinational readback sampled one clock later
  task automatic readReg(input CfgAddrT addr, output logic [7:0] data);
    @(posedge getDataTrig);
    cfgAddr <= addr;
    @(posedge getDataTrig);
    data = cfgRdata;
  endtask

  task automatic waitAligned();
    logic [7:0] st;
    st = 8'h00;
    for (int t = 0; t < 100 && !st[0]; t++)
      readReg(addrStatus, st);
    if (!st[0])
      failNow("Link did not align within 200 clocks");
  endtask

  task automatic waitSendDone();
    int t;
    for (t = 0; t < 3000 && sendQ.size() != 0; t++)
      @(posedge getDataTrig);
    if (sendQ.size() != 0)
      failNow("Encoder stopped taking words");
  endtask

  task automatic waitDrained();
    int t;
    for (t = 0; t < 400 && expQ.size() != 0; t++)
      @(posedge getDataTrig);
    if (expQ.size() != 0)
      failNow("Expected words never arrived in the FIFO");
  endtask

  // Counts encoder slots to let the link settle
  task automatic waitSlots(input int n);
    logic seen;
    for (int s = 0; s < n; s++)
    begin
      seen = 1'b0;
      for (int t = 0; t < 20 && !seen; t++)
      begin
        @(posedge getDataTrig);
        seen = wordReq;
      end
      if (!seen)
        failNow("No wordReq from the encoder within 20 clocks");
    end
  endtask

  task automatic pushWord(input logic valid, input delimT delim, input logic [7:0] data,
                          input logic corrupt);
    sendQ.push_back({corrupt, valid, delim, data});
  endtask

  // SOP then 1 to 6 random bytes and EOP, then up to 2 idle slots
  task automatic queuePackets(input int nPkts);
    int len;
    int gap;
    for (int p = 0; p < nPkts; p++)
    begin
      len = 1 + ($unsigned($random(seed)) % 6);
      gap = $unsigned($random(seed)) % 3;
      pushWord(1'b1, delimSop, 8'h00, 1'b0);
      for (int i = 0; i < len; i++)
        pushWord(1'b1, delimData, 8'($random(seed)), 1'b0);
      pushWord(1'b1, delimEop, 8'h00, 1'b0);
      for (int i = 0; i < gap; i++)
        pushWord(1'b0, delimData, 8'h00, 1'b0);  // wordValid low
    end
  endtask

  task automatic linkUp(input int pairs, input logic [7:0] ctrl);
    logic [7:0] errNow;
    delayPairs <= pairs;
    resetDut();
    writeReg(addrCtrl, ctrl);
    waitAligned();
    readReg(addrErrCount, errNow);
    checkEqual(errNow, 0, "errCount after alignment");
  endtask

  task automatic runTraffic(input int nPkts);
    logic [7:0] errNow;
    queuePackets(nPkts);
    waitSendDone();
    waitDrained();
    waitSlots(4);  // Catch stray entries
    checkEqual(fifoEmpty, 1, "fifoEmpty after traffic");
    readReg(addrErrCount, errNow);
    checkEqual(errNow, 0, "errCount after traffic");
  endtask

  initial
  begin
    logic [7:0] st;
    logic [7:0] errNow;
    rstN       = 1'b0;
    cfgWr      = 1'b0;
    cfgAddr    = addrCtrl;
    cfgWdata   = 8'h00;
    readEn     = 1'b1;
    expectOn   = 1'b1;
    delayPairs = 0;

    // Alignment and packets at every skew
    for (int d = 0; d < 5; d++)
    begin
      linkUp(d, 8'h01);
      runTraffic(4);
    end

    // Both sides swapped and reversed and then reversed only
    linkUp(2, 8'h0F);
    runTraffic(4);
    linkUp(3, 8'h09);
    runTraffic(3);

    // Unequal pair swap never locks
    delayPairs <= 1;
    resetDut();
    expectOn <= 1'b0;
    writeReg(addrCtrl, 8'h03);
    queuePackets(2);
    for (int i = 0; i < 150; i++)
    begin
      readReg(addrStatus, st);
      checkEqual(st[0], 0, "aligned with unequal pair swap");
    end
    waitSendDone();
    expectOn <= 1'b1;
    writeReg(addrCtrl, 8'h01);  // Equal settings again
    waitAligned();
    runTraffic(3);

    // Overflow with reads held off
    linkUp(4, 8'h01);
    readEn <= 1'b0;
    pushWord(1'b1, delimSop, 8'h00, 1'b0);
    for (int i = 0; i < FifoDepth + 4; i++)
      pushWord(1'b1, delimData, 8'($random(seed)), 1'b0);
    pushWord(1'b1, delimEop, 8'h00, 1'b0);
    waitSendDone();
    waitSlots(5);
    checkEqual(fifoFull, 1, "fifoFull with reads held off");
    readReg(addrStatus, st);
    checkEqual(st, 8'h03, "status after overflow");
    while (expQ.size() > FifoDepth)
      expQ.delete(expQ.size() - 1);  // Dropped at the FIFO
    readEn <= 1'b1;
    waitDrained();
    waitSlots(2);
    checkEqual(fifoEmpty, 1, "fifoEmpty after overflow readback");
    writeReg(addrStatus, 8'h02);
    readReg(addrStatus, st);
    checkEqual(st, 8'h01, "status after overflow clear");

    // One flipped bit costs one symbol
    linkUp(3, 8'h01);
    pushWord(1'b1, delimSop, 8'h00, 1'b0);
    for (int i = 0; i < 3; i++)
      pushWord(1'b1, delimData, 8'($random(seed)), 1'b0);
    pushWord(1'b1, delimData, 8'h00, 1'b1);  // D.0.0 hit on the wire
    for (int i = 0; i < 3; i++)
      pushWord(1'b1, delimData, 8'($random(seed)), 1'b0);
    pushWord(1'b1, delimEop, 8'h00, 1'b0);
    pushWord(1'b0, delimData, 8'h00, 1'b0);
    waitSendDone();
    waitDrained();
    waitSlots(3);
    checkEqual(fifoEmpty, 1, "fifoEmpty after bit flip");
    readReg(addrErrCount, errNow);
    checkEqual(errNow >= 8'd1, 1, "errCount raised by bit flip");

    if (UUT.uChk.assertFails == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      failNow("A bound assertion failed during the run");
  end

endmodule

//--- elinkLoop.f
design/elinkPkg.sv
design/elinkCfg.sv
design/enc8b10b.sv
design/elinkSer.sv
design/elinkDes.sv
design/dec8b10b.sv
design/elinkRxFifo.sv
design/elinkLoop.sv
test/elinkLoop_chk.sv
test/tbElinkLoop.sv
